//--- build.f
src/csr_io_pkg.sv
src/csr_unit.sv
src/io_port.sv
src/tx_fifo.sv
src/uart_tx.sv
src/io_top.sv
dv/io_assert.sv
dv/io_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= io_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/io_tb.sv
// testbench for the I/O corner, applies a table of CSR requests and decodes the UART line
`default_nettype none
`timescale 1ns/100ps

module io_tb;

  localparam int FifoDepth  = 4;
  localparam int ClksPerBit = 4;

  // short address names for the table
  localparam csr_io_pkg::csr_addr_t Led   = csr_io_pkg::LedAddr;
  localparam csr_io_pkg::csr_addr_t Btn   = csr_io_pkg::BtnAddr;
  localparam csr_io_pkg::csr_addr_t Udata = csr_io_pkg::UartDataAddr;
  localparam csr_io_pkg::csr_addr_t Ustat = csr_io_pkg::UartStatAddr;
  localparam csr_io_pkg::csr_addr_t Bad   = 12'h7C4;

  typedef struct {
    string                           name;
    csr_io_pkg::csr_op_t             op;
    csr_io_pkg::csr_addr_t           addr;
    logic [4:0]                      zimm;
    logic [31:0]                     data;
    logic [csr_io_pkg::BtnWidth-1:0] btn;
    logic                            wait_idle;
    logic [31:0]                     exp_data;
    logic                            exp_err;
    logic [csr_io_pkg::LedWidth-1:0] exp_led;
  } row_t;

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic                            req_valid;
  logic                            req_ready;
  csr_io_pkg::csr_op_t             req_op;
  csr_io_pkg::csr_addr_t           req_addr;
  logic [4:0]                      req_zimm;
  logic [31:0]                     req_data;
  logic                            rsp_valid;
  logic                            rsp_ready;
  logic [31:0]                     rsp_data;
  logic                            rsp_error;
  logic [csr_io_pkg::BtnWidth-1:0] btn;
  logic [csr_io_pkg::LedWidth-1:0] led;
  logic                            tx;

  row_t       rows[$];
  logic [7:0] exp_bytes[$];
  logic [7:0] rx_bytes[$];
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  int         limit  = 0;
  int         seed   = 32'h6c28_7bdc;

  io_top #(
    .FifoDepth (FifoDepth),
    .ClksPerBit(ClksPerBit)
  ) DUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: no progress after %0d cycles, run stopped", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_led(input string name, input logic [csr_io_pkg::LedWidth-1:0] exp,
                           input logic [csr_io_pkg::LedWidth-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_row(input string name, input csr_io_pkg::csr_op_t op,
                         input csr_io_pkg::csr_addr_t addr, input logic [4:0] zimm,
                         input logic [31:0] data, input logic [3:0] btn_in,
                         input logic wait_idle, input logic [31:0] exp_data,
                         input logic exp_err, input logic [3:0] exp_led);
    row_t r;
    r.name      = name;
    r.op        = op;
    r.addr      = addr;
    r.zimm      = zimm;
    r.data      = data;
    r.btn       = btn_in;
    r.wait_idle = wait_idle;
    r.exp_data  = exp_data;
    r.exp_err   = exp_err;
    r.exp_led   = exp_led;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // led read-write, set and clear, the response is always the old value
    add_row("led_rw",     csr_io_pkg::CsrRw,  Led,   5'd1, 32'ha, 4'h0, 1'b0, 32'h0, 1'b0, 4'ha);
    add_row("led_rs",     csr_io_pkg::CsrRs,  Led,   5'd2, 32'h5, 4'h0, 1'b0, 32'ha, 1'b0, 4'hf);
    add_row("led_rc",     csr_io_pkg::CsrRc,  Led,   5'd3, 32'h3, 4'h0, 1'b0, 32'hf, 1'b0, 4'hc);
    add_row("led_rwi",    csr_io_pkg::CsrRwi, Led,  5'h13, '1,    4'h0, 1'b0, 32'hc, 1'b0, 4'h3);
    add_row("led_rsi",    csr_io_pkg::CsrRsi, Led,   5'd4, '0,    4'h0, 1'b0, 32'h3, 1'b0, 4'h7);
    add_row("led_rci",    csr_io_pkg::CsrRci, Led,   5'd1, '1,    4'h0, 1'b0, 32'h7, 1'b0, 4'h6);
    // zero operand source means no write
    add_row("led_rs_x0",  csr_io_pkg::CsrRs,  Led,   5'd0, '1,    4'h0, 1'b0, 32'h6, 1'b0, 4'h6);
    add_row("led_rc_x0",  csr_io_pkg::CsrRc,  Led,   5'd0, '1,    4'h0, 1'b0, 32'h6, 1'b0, 4'h6);
    add_row("led_rci_z0", csr_io_pkg::CsrRci, Led,   5'd0, '0,    4'h0, 1'b0, 32'h6, 1'b0, 4'h6);
    add_row("btn_read",   csr_io_pkg::CsrRs,  Btn,   5'd0, '0,    4'h5, 1'b0, 32'h5, 1'b0, 4'h6);
    add_row("btn_rc_x0",  csr_io_pkg::CsrRc,  Btn,   5'd0, '1,    4'h9, 1'b0, 32'h9, 1'b0, 4'h6);
    add_row("btn_rsi_z0", csr_io_pkg::CsrRsi, Btn,   5'd0, '0,    4'h9, 1'b0, 32'h9, 1'b0, 4'h6);
    // read-only and unknown addresses
    add_row("btn_rw",     csr_io_pkg::CsrRw,  Btn,   5'd1, '0,    4'h9, 1'b0, 32'h9, 1'b1, 4'h6);
    add_row("stat_rw",    csr_io_pkg::CsrRw,  Ustat, 5'd1, '1,    4'h9, 1'b0, 32'h2, 1'b1, 4'h6);
    add_row("bad_addr",   csr_io_pkg::CsrRs,  Bad,   5'd0, '0,    4'h9, 1'b0, 32'h0, 1'b1, 4'h6);
    add_row("led_keep",   csr_io_pkg::CsrRs,  Led,   5'd0, '0,    4'h9, 1'b0, 32'h6, 1'b0, 4'h6);
    // two frames, then the line goes idle
    add_row("uart_a5",    csr_io_pkg::CsrRw,  Udata, 5'd1, 32'ha5, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("uart_c3",    csr_io_pkg::CsrRw,  Udata, 5'd1, 32'hc3, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("uart_rd",    csr_io_pkg::CsrRs,  Udata, 5'd0, '0,    4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("stat_idle",  csr_io_pkg::CsrRs,  Ustat, 5'd0, '0,    4'h9, 1'b1, 32'h2, 1'b0, 4'h6);
    // first byte goes straight to the shifter, four more fill the FIFO
    add_row("ovf_11",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h11, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("ovf_22",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h22, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("ovf_33",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h33, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("ovf_44",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h44, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("ovf_55",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h55, 4'h9, 1'b0, 32'h0, 1'b0, 4'h6);
    add_row("ovf_66",     csr_io_pkg::CsrRw,  Udata, 5'd1, 32'h66, 4'h9, 1'b0, 32'h0, 1'b1, 4'h6);
    add_row("stat_full",  csr_io_pkg::CsrRs,  Ustat, 5'd0, '0,    4'h9, 1'b0, 32'h5, 1'b0, 4'h6);
    add_row("ovf_rwi",    csr_io_pkg::CsrRwi, Udata, 5'd7, '0,    4'h9, 1'b0, 32'h0, 1'b1, 4'h6);
    add_row("stat_done",  csr_io_pkg::CsrRs,  Ustat, 5'd0, '0,    4'h9, 1'b1, 32'h2, 1'b0, 4'h6);
  endtask

  // a successful write to the data register queues one byte
  function automatic logic sends_byte(input row_t r);
    logic writes;
    writes = (r.op == csr_io_pkg::CsrRw) || (r.op == csr_io_pkg::CsrRwi) || (r.zimm != 5'd0);
    return writes && !r.exp_err && (r.addr == Udata);
  endfunction

  function automatic logic [7:0] row_byte(input row_t r);
    if (r.op == csr_io_pkg::CsrRwi || r.op == csr_io_pkg::CsrRsi || r.op == csr_io_pkg::CsrRci) begin
      return {3'b000, r.zimm};
    end
    return r.data[7:0];
  endfunction

  task automatic apply_row(input row_t r);
    int rnd;
    int stall;
    rnd   = $random(seed);
    stall = (rnd[1:0] == 2'b00) ? (rnd[2] ? 2 : 1) : 0;
    if (r.wait_idle) begin
      while (rx_bytes.size() != exp_bytes.size()) @(negedge clk);
      repeat (ClksPerBit) @(negedge clk);
    end
    @(posedge clk);
    #2;
    // two synchroniser stages plus one spare cycle
    if (btn !== r.btn) begin
      btn = r.btn;
      repeat (3) @(posedge clk);
      #2;
    end
    req_op    = r.op;
    req_addr  = r.addr;
    req_zimm  = r.zimm;
    req_data  = r.data;
    req_valid = 1'b1;
    rsp_ready = (stall == 0);
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    if (sends_byte(r)) begin
      exp_bytes.push_back(row_byte(r));
    end
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    check_data(r.name, r.exp_data, rsp_data);
    check_flag(r.name, r.exp_err, rsp_error);
    check_led(r.name, r.exp_led, led);
    repeat (stall) begin
      @(negedge clk);
      check_flag({r.name, " held valid"}, 1'b1, rsp_valid);
      check_flag({r.name, " req_ready"}, 1'b0, req_ready);
      check_data({r.name, " held data"}, r.exp_data, rsp_data);
    end
    if (stall > 0) begin
      @(posedge clk);
      #2;
      rsp_ready = 1'b1;
    end
    @(posedge clk);
  endtask

  // 8N1 receiver, samples each bit near its middle
  initial begin : uart_monitor
    logic [7:0] b;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      repeat (ClksPerBit / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        $display("framing error: start bit on tx did not stay low");
        errors++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (ClksPerBit) @(negedge clk);
        b[i] = tx;
      end
      repeat (ClksPerBit) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("framing error: stop bit on tx was not high");
        errors++;
      end
      rx_bytes.push_back(b);
    end
  end

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = csr_io_pkg::CsrRw;
    req_addr  = '0;
    req_zimm  = '0;
    req_data  = '0;
    rsp_ready = 1'b1;
    btn       = '0;
    build_table();
    limit = rows.size() * 20 + (FifoDepth + 2) * 10 * ClksPerBit * 2 + 200;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset req_ready", 1'b1, req_ready);
    check_flag("reset rsp_valid", 1'b0, rsp_valid);
    check_led("reset led", '0, led);
    check_flag("reset tx", 1'b1, tx);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    // long enough for a stray extra frame to show up
    while (rx_bytes.size() < exp_bytes.size()) @(negedge clk);
    repeat (12 * ClksPerBit) @(negedge clk);
    if (rx_bytes.size() != exp_bytes.size()) begin
      $display("received %0d bytes on tx but %0d were written", rx_bytes.size(),
               exp_bytes.size());
      errors++;
    end else begin
      foreach (exp_bytes[i]) begin
        check_byte($sformatf("tx byte %0d", i), exp_bytes[i], rx_bytes[i]);
      end
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/io_assert.sv
// concurrent checks on the CSR handshake, FIFO push and UART idle line, bound into io_top
`default_nettype none
`timescale 1ns/100ps

module io_assert (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req_valid,
  input logic                  req_ready,
  input csr_io_pkg::csr_op_t   req_op,
  input csr_io_pkg::csr_addr_t req_addr,
  input logic [4:0]            req_zimm,
  input logic [31:0]           req_data,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input logic                  push_valid,
  input logic                  fifo_full,
  input logic                  fifo_empty,
  input logic                  tx_ready,
  input logic                  tx
);

  // a stalled request keeps valid and its fields
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req_op) && $stable(req_addr) &&
                                $stable(req_zimm) && $stable(req_data))
    else $error("CSR request changed while stalled");

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid)
    else $error("CSR response dropped before it was taken");

  // a push lands in a FIFO with room and leaves it non-empty
  no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> !fifo_full ##1 !fifo_empty)
    else $error("push issued while the FIFO was full or the byte was lost");

  // idle line is high
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_ready |-> tx)
    else $error("tx low while the UART was idle");

endmodule

bind io_top io_assert u_io_assert (
  .clk,
  .rst_n,
  .req_valid,
  .req_ready,
  .req_op,
  .req_addr,
  .req_zimm,
  .req_data,
  .rsp_valid,
  .rsp_ready,
  .push_valid,
  .fifo_full,
  .fifo_empty,
  .tx_ready,
  .tx
);

`default_nettype wire

//--- src/io_top.sv
// top level of the I/O corner, wiring the CSR unit to the LED/button port, FIFO and UART
`default_nettype none
`timescale 1ns/100ps

module io_top #(
  parameter int FifoDepth  = 8,
  parameter int ClksPerBit = 868
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // csr request
  input  logic                            req_valid,
  output logic                            req_ready,
  input  csr_io_pkg::csr_op_t             req_op,
  input  csr_io_pkg::csr_addr_t           req_addr,
  input  logic [4:0]                      req_zimm,
  input  logic [31:0]                     req_data,
  // csr response
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output logic [31:0]                     rsp_data,
  output logic                            rsp_error,
  // board pins
  input  logic [csr_io_pkg::BtnWidth-1:0] btn,
  output logic [csr_io_pkg::LedWidth-1:0] led,
  output logic                            tx
);

  logic                            led_we;
  logic [csr_io_pkg::LedWidth-1:0] led_wdata;
  logic [csr_io_pkg::LedWidth-1:0] led_value;
  logic [csr_io_pkg::BtnWidth-1:0] btn_value;
  logic                            push_valid;
  logic [7:0]                      push_byte;
  logic                            fifo_full;
  logic                            fifo_empty;
  logic                            tx_valid;
  logic                            tx_ready;
  logic [7:0]                      tx_byte;
  logic                            tx_busy;

  csr_unit u_csr_unit (
    .clk,
    .rst_n,
    .req_valid,
    .req_ready,
    .req_op,
    .req_addr,
    .req_zimm,
    .req_data,
    .rsp_valid,
    .rsp_ready,
    .rsp_data,
    .rsp_error,
    .led_value,
    .btn_value,
    .fifo_full,
    .fifo_empty,
    .tx_busy,
    .led_we,
    .led_wdata,
    .push_valid,
    .push_byte
  );

  io_port u_io_port (
    .clk,
    .rst_n,
    .led_we,
    .led_wdata,
    .btn,
    .led,
    .led_value,
    .btn_value
  );

  tx_fifo #(
    .FifoDepth(FifoDepth)
  ) u_tx_fifo (
    .clk,
    .rst_n,
    .push_valid,
    .push_byte,
    .full     (fifo_full),
    .empty    (fifo_empty),
    .tx_valid,
    .tx_ready,
    .tx_byte
  );

  uart_tx #(
    .ClksPerBit(ClksPerBit)
  ) u_uart_tx (
    .clk,
    .rst_n,
    .tx_valid,
    .tx_byte,
    .tx_ready,
    .busy     (tx_busy),
    .tx
  );

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// 8N1 UART transmitter that pops bytes from the FIFO and shifts them out on tx
`default_nettype none
`timescale 1ns/100ps

module uart_tx #(
  parameter int ClksPerBit = 868
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       busy,
  output logic       tx
);

  localparam int CntWidth = $clog2(ClksPerBit);

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StStart = 2'd1;
  localparam logic [1:0] StData  = 2'd2;
  localparam logic [1:0] StStop  = 2'd3;

  logic [1:0]          state;
  logic [CntWidth-1:0] cnt;
  logic [2:0]          bit_idx;
  logic [7:0]          shreg;
  logic                bit_done;

  assign tx_ready = (state == StIdle);
  assign busy     = !tx_ready;
  assign bit_done = (cnt == CntWidth'(ClksPerBit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= StIdle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        StIdle: begin
          // pop edge, start bit begins right after it
          if (tx_valid) begin
            state <= StStart;
            cnt   <= '0;
            tx    <= 1'b0;
          end
        end
        StStart: begin
          if (bit_done) begin
            state   <= StData;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= shreg[0];
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        StData: begin
          if (bit_done) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= StStop;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shreg[1];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (bit_done) begin
            state <= StIdle;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (tx_ready && tx_valid) begin
      shreg <= tx_byte;
    end else if (state == StData && bit_done) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- src/tx_fifo.sv
// byte FIFO that buffers UART data written by the CSR unit until the transmitter takes it
`default_nettype none
`timescale 1ns/100ps

module tx_fifo #(
  parameter int FifoDepth = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  // write side
  input  logic       push_valid,
  input  logic [7:0] push_byte,
  output logic       full,
  output logic       empty,
  // read side
  output logic       tx_valid,
  input  logic       tx_ready,
  output logic [7:0] tx_byte
);

  localparam int AddrWidth = $clog2(FifoDepth);

  logic [7:0]         mem [FifoDepth];
  // extra msb tells full from empty
  logic [AddrWidth:0] wr_ptr;
  logic [AddrWidth:0] rd_ptr;
  logic               do_push;
  logic               do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AddrWidth] != rd_ptr[AddrWidth]) &&
                 (wr_ptr[AddrWidth-1:0] == rd_ptr[AddrWidth-1:0]);

  assign tx_valid = !empty;
  assign tx_byte  = mem[rd_ptr[AddrWidth-1:0]];

  // push while full is dropped
  assign do_push = push_valid && !full;
  assign do_pop  = tx_valid && tx_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AddrWidth-1:0]] <= push_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/io_port.sv
// LED output register and button input synchroniser, read back through the CSR unit
`default_nettype none
`timescale 1ns/100ps

module io_port (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            led_we,
  input  logic [csr_io_pkg::LedWidth-1:0] led_wdata,
  input  logic [csr_io_pkg::BtnWidth-1:0] btn,
  output logic [csr_io_pkg::LedWidth-1:0] led,
  output logic [csr_io_pkg::LedWidth-1:0] led_value,
  output logic [csr_io_pkg::BtnWidth-1:0] btn_value
);

  logic [csr_io_pkg::LedWidth-1:0] led_q;
  logic [csr_io_pkg::BtnWidth-1:0] btn_meta;
  logic [csr_io_pkg::BtnWidth-1:0] btn_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q <= '0;
    end else if (led_we) begin
      led_q <= led_wdata;
    end
  end

  // buttons are asynchronous to clk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  assign led       = led_q;
  assign led_value = led_q;
  assign btn_value = btn_sync;

endmodule

`default_nettype wire

//--- src/csr_unit.sv
// executes CSR requests against the LED, button and UART registers and returns the old value
`default_nettype none
`timescale 1ns/100ps

module csr_unit (
  input  logic                                clk,
  input  logic                                rst_n,
  // request
  input  logic                                req_valid,
  output logic                                req_ready,
  input  csr_io_pkg::csr_op_t                 req_op,
  input  csr_io_pkg::csr_addr_t               req_addr,
  input  logic [4:0]                          req_zimm,
  input  logic [31:0]                         req_data,
  // response
  output logic                                rsp_valid,
  input  logic                                rsp_ready,
  output logic [31:0]                         rsp_data,
  output logic                                rsp_error,
  // peer state
  input  logic [csr_io_pkg::LedWidth-1:0]     led_value,
  input  logic [csr_io_pkg::BtnWidth-1:0]     btn_value,
  input  logic                                fifo_full,
  input  logic                                fifo_empty,
  input  logic                                tx_busy,
  // peer writes
  output logic                                led_we,
  output logic [csr_io_pkg::LedWidth-1:0]     led_wdata,
  output logic                                push_valid,
  output logic [7:0]                          push_byte
);

  logic        accept;
  logic        imm_form;
  logic        do_write;
  logic [31:0] operand;
  logic [31:0] old_value;
  logic [31:0] new_value;
  logic        addr_known;
  logic        addr_ro;
  logic        is_led;
  logic        is_uart_data;
  logic        req_error;

  // one operation in flight, a pending response blocks the next request
  assign req_ready = !rsp_valid;
  assign accept    = req_valid && req_ready;

  assign imm_form = (req_op == csr_io_pkg::CsrRwi) ||
                    (req_op == csr_io_pkg::CsrRsi) ||
                    (req_op == csr_io_pkg::CsrRci);

  assign operand = imm_form ? {27'b0, req_zimm} : req_data;

  // for register forms req_zimm carries the rs1 index
  always_comb begin
    do_write  = 1'b0;
    new_value = old_value;
    case (req_op)
      csr_io_pkg::CsrRw, csr_io_pkg::CsrRwi: begin
        do_write  = 1'b1;
        new_value = operand;
      end
      csr_io_pkg::CsrRs, csr_io_pkg::CsrRsi: begin
        do_write  = |req_zimm;
        new_value = old_value | operand;
      end
      csr_io_pkg::CsrRc, csr_io_pkg::CsrRci: begin
        do_write  = |req_zimm;
        new_value = old_value & ~operand;
      end
      default: begin
        do_write = 1'b0;
      end
    endcase
  end

  // address decode and read mux
  always_comb begin
    old_value  = '0;
    addr_known = 1'b1;
    addr_ro    = 1'b0;
    case (req_addr)
      csr_io_pkg::LedAddr: begin
        old_value[csr_io_pkg::LedWidth-1:0] = led_value;
      end
      csr_io_pkg::BtnAddr: begin
        old_value[csr_io_pkg::BtnWidth-1:0] = btn_value;
        addr_ro = 1'b1;
      end
      csr_io_pkg::UartDataAddr: begin
        old_value = '0;
      end
      csr_io_pkg::UartStatAddr: begin
        old_value[csr_io_pkg::StatFullBit]  = fifo_full;
        old_value[csr_io_pkg::StatEmptyBit] = fifo_empty;
        old_value[csr_io_pkg::StatBusyBit]  = tx_busy;
        addr_ro = 1'b1;
      end
      default: begin
        addr_known = 1'b0;
      end
    endcase
  end

  assign is_led       = (req_addr == csr_io_pkg::LedAddr);
  assign is_uart_data = (req_addr == csr_io_pkg::UartDataAddr);

  // a full FIFO drops the byte and reports it
  assign req_error = !addr_known ||
                     (do_write && addr_ro) ||
                     (do_write && is_uart_data && fifo_full);

  assign led_we     = accept && do_write && !req_error && is_led;
  assign led_wdata  = new_value[csr_io_pkg::LedWidth-1:0];
  assign push_valid = accept && do_write && !req_error && is_uart_data;
  assign push_byte  = operand[7:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // held while rsp_valid waits for rsp_ready
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data  <= old_value;
      rsp_error <= req_error;
    end
  end

endmodule

`default_nettype wire

//--- src/csr_io_pkg.sv
// shared CSR addresses, operation encodings and board I/O widths for the I/O corner of the core
`default_nettype none

package csr_io_pkg;

  // same encoding as funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    CsrRw  = 3'b001,
    CsrRs  = 3'b010,
    CsrRc  = 3'b011,
    CsrRwi = 3'b101,
    CsrRsi = 3'b110,
    CsrRci = 3'b111
  } csr_op_t;

  typedef logic [11:0] csr_addr_t;

  // machine-level custom read-write range
  localparam csr_addr_t LedAddr      = 12'h7C0;
  localparam csr_addr_t BtnAddr      = 12'h7C1;
  localparam csr_addr_t UartDataAddr = 12'h7C2;
  localparam csr_addr_t UartStatAddr = 12'h7C3;

  // board pins
  localparam int LedWidth = 4;
  localparam int BtnWidth = 4;

  // uart status register layout
  localparam int StatFullBit  = 0;
  localparam int StatEmptyBit = 1;
  localparam int StatBusyBit  = 2;

endpackage

`default_nettype wire
